// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lsu_properties.sv
`timescale 1ns/1ps

// Credit and reset rules seen at the lsu_top boundary
module lsu_properties #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic        clk,
    input logic        arst_n_i,
    input logic        req_valid_i,
    input logic        req_credit_o,
    input logic        rsp_valid_o,
    input logic [31:0] rsp_data_o,
    input logic        rsp_credit_i
);

    int out_crd;     // Consumer slots still free
    int in_flight;   // Requests not yet credited back
    int n_fail = 0;  // Assertion failures so far

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_crd   <= OUT_CREDITS;
            in_flight <= 0;
        end else begin
            out_crd   <= out_crd - int'(rsp_valid_o) + int'(rsp_credit_i);
            in_flight <= in_flight + int'(req_valid_i) - int'(req_credit_o);
        end
    end

    rsp_needs_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o |-> out_crd > 0)
        else begin
            $error("Response presented with no output credit");
            n_fail++;
        end

    producer_in_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
        in_flight <= IN_DEPTH)
        else begin
            $error("Producer exceeded its input credits");
            n_fail++;
        end

    rsp_data_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o |-> !$isunknown(rsp_data_o))
        else begin
            $error("Response data unknown while valid");
            n_fail++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n_i) |-> !rsp_valid_o && !req_credit_o)
        else begin
            $error("Handshake outputs active right after reset");
            n_fail++;
        end

endmodule

bind lsu_top lsu_properties #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) i_props (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_credit_i (rsp_credit_i)
);

// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*;;

    localparam int MEM_WORDS    = 256;
    localparam int IN_DEPTH     = 4;
    localparam int RES_DEPTH    = 4;
    localparam int OUT_CREDITS  = 2;
    localparam int MEM_BYTES    = MEM_WORDS * 4;
    localparam int AB           = $clog2(MEM_BYTES);
    localparam int N_RANDOM     = 600;
    localparam int N_DIRECTED   = 60;   // Upper bound on the directed requests
    localparam int STALL_CYCLES = 200;  // Consumer holds its credits this long
    localparam int CYCLE_LIMIT  = 40 * (N_RANDOM + N_DIRECTED) + STALL_CYCLES;

    logic            clk = 1'b0;
    logic            arst_n_i;
    logic            req_valid_i;
    logic            req_store_i;
    logic [2:0]      req_funct3_i;
    logic [XLEN-1:0] req_base_i;
    logic [11:0]     req_offset_i;
    logic [XLEN-1:0] req_wdata_i;
    logic            req_credit_o;
    logic            rsp_valid_o;
    logic [XLEN-1:0] rsp_data_o;
    logic            rsp_fault_o;
    logic            rsp_credit_i;

    logic [7:0]  ref_mem [MEM_BYTES] = '{default: '0};  // Byte model of data_mem
    logic [32:0] exp_q [$];                            // {fault, data} in order
    logic [15:0] stim_lfsr = 16'd52;
    logic [15:0] cons_lfsr = 16'd52;                   // Consumer delays
    int          sent_cnt;
    int          back_cnt;
    int          errors;
    int          n_checked;
    int          cycles;
    int          owed;
    int          delay;
    logic        hold_credits = 1'b0;

    always #20 clk = ~clk;

    lsu_top #(
        .MEM_WORDS   (MEM_WORDS),
        .IN_DEPTH    (IN_DEPTH),
        .RES_DEPTH   (RES_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_dut (.*);

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n, inout logic [15:0] st);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
            v  = {v[30:0], st[0]};
        end
        return v;
    endfunction

    // Expected {fault, data} of one request and its store into ref_mem
    function automatic logic [32:0] ref_access(input logic st, input logic [2:0] f3,
            input logic [31:0] base, input logic [11:0] off, input logic [31:0] wd);
        logic [31:0]   addr;
        logic [31:0]   val;
        logic [AB-1:0] idx;
        logic          bad;
        int            nbytes;
        addr   = base + {{20{off[11]}}, off};
        nbytes = 1 << f3[1:0];
        bad    = st ? (f3 > 3'd2) : (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7);
        if ((addr & 32'(nbytes - 1)) != 0) bad = 1'b1;                 // Natural alignment
        if ({32'd0, addr} + 64'(nbytes) > 64'(MEM_BYTES)) bad = 1'b1;  // Past the end
        if (bad) return {1'b1, 32'hDEAD_BEEF};
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            idx = addr[AB-1:0] + AB'(i);   // Little-endian
            if (st) ref_mem[idx] = wd[8*i +: 8];
            else val[8*i +: 8] = ref_mem[idx];
        end
        if (st) return 33'd0;
        if (!f3[2] && nbytes == 1) val = {{24{val[7]}}, val[7:0]};
        if (!f3[2] && nbytes == 2) val = {{16{val[15]}}, val[15:0]};
        return {1'b0, val};
    endfunction

    task automatic compare_val(input string what, input logic [32:0] got,
                               input logic [32:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Drive one request on a falling edge once an input credit is held
    task automatic send_req(input logic st, input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] off, input logic [31:0] wd);
        while (sent_cnt - back_cnt >= IN_DEPTH) @(negedge clk);
        req_valid_i  = 1'b1;
        req_store_i  = st;
        req_funct3_i = f3;
        req_base_i   = base;
        req_offset_i = off;
        req_wdata_i  = wd;
        sent_cnt++;
        exp_q.push_back(ref_access(st, f3, base, off, wd));
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic finish_run();
        errors += i_dut.i_props.n_fail;
        $display("Result: %0d responses checked, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (req_credit_o) back_cnt++;  // Registered pulse still shows its old value here
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles with %0d responses pending",
                     cycles, exp_q.size());
            errors++;
            finish_run();
        end
    end

    // Each response against the oldest expected one
    always @(negedge clk) begin
        if (arst_n_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: response at %0t with no request outstanding", $time);
                errors++;
            end else begin
                compare_val("response", {rsp_fault_o, rsp_data_o}, exp_q.pop_front());
                n_checked++;
            end
        end
    end

    // Consumer drains each beat and returns its slot after a random delay
    always @(negedge clk) begin
        rsp_credit_i = 1'b0;
        if (rsp_valid_o === 1'b1) owed++;
        if (!hold_credits && owed > 0) begin
            if (delay == 0) begin
                rsp_credit_i = 1'b1;
                owed--;
                delay = int'(lfsr_bits(2, cons_lfsr));
            end else begin
                delay--;
            end
        end
    end

    initial begin
        logic        st;
        logic [1:0]  size;
        logic [2:0]  f3;
        logic [31:0] base;
        logic [31:0] rnd;
        int          drain;
        req_valid_i  = 1'b0;
        req_store_i  = 1'b0;
        req_funct3_i = 3'd0;
        req_base_i   = '0;
        req_offset_i = '0;
        req_wdata_i  = '0;
        rsp_credit_i = 1'b0;
        arst_n_i     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Word store and load back
        send_req(1'b1, 3'd2, 32'h100, 12'h000, 32'h1234_5678);
        send_req(1'b0, 3'd2, 32'h0FC, 12'h004, 32'h0);
        // Sub-word stores into separate lanes and then every load flavor
        send_req(1'b1, 3'd0, 32'h200, 12'h000, 32'hCAFE_0080);
        send_req(1'b1, 3'd0, 32'h200, 12'h001, 32'h0000_007F);
        send_req(1'b1, 3'd1, 32'h210, 12'hFF2, 32'h1111_8001);  // Negative offset
        send_req(1'b0, 3'd0, 32'h200, 12'h000, 32'h0);
        send_req(1'b0, 3'd4, 32'h200, 12'h000, 32'h0);
        send_req(1'b0, 3'd0, 32'h200, 12'h001, 32'h0);
        send_req(1'b0, 3'd1, 32'h200, 12'h002, 32'h0);
        send_req(1'b0, 3'd5, 32'h200, 12'h002, 32'h0);
        send_req(1'b0, 3'd2, 32'h200, 12'h000, 32'h0);
        send_req(1'b0, 3'd4, 32'h200, 12'h003, 32'h0);
        // Misaligned and out-of-range accesses leave memory untouched
        send_req(1'b1, 3'd1, 32'h300, 12'h001, 32'h0000_BEEF);
        send_req(1'b1, 3'd2, 32'h300, 12'h002, 32'hFFFF_FFFF);
        send_req(1'b0, 3'd2, 32'h300, 12'h005, 32'h0);
        send_req(1'b0, 3'd1, 32'h3FF, 12'h000, 32'h0);
        send_req(1'b1, 3'd2, 32'h3FC, 12'h004, 32'h5555_5555);
        send_req(1'b1, 3'd0, 32'h400, 12'h000, 32'h0000_0055);
        send_req(1'b0, 3'd2, 32'h000, 12'hFFC, 32'h0);          // Wraps below zero
        send_req(1'b1, 3'd0, 32'h3FF, 12'h000, 32'h0000_00A5);  // Last legal byte
        send_req(1'b0, 3'd4, 32'h3FF, 12'h000, 32'h0);
        send_req(1'b0, 3'd2, 32'h300, 12'h000, 32'h0);
        send_req(1'b0, 3'd2, 32'h304, 12'h000, 32'h0);
        send_req(1'b0, 3'd2, 32'h000, 12'h000, 32'h0);          // Word index of 0x400
        // Illegal funct3 codes
        send_req(1'b0, 3'd3, 32'h100, 12'h000, 32'h0);
        send_req(1'b0, 3'd6, 32'h100, 12'h000, 32'h0);
        send_req(1'b0, 3'd7, 32'h100, 12'h000, 32'h0);
        for (int f = 3; f < 8; f++) send_req(1'b1, 3'(f), 32'h100, 12'h000, 32'hFFFF_FFFF);
        send_req(1'b0, 3'd2, 32'h100, 12'h000, 32'h0);

        // Consumer sits on its credits for a while
        hold_credits = 1'b1;
        fork
            begin
                for (int n = 0; n < 16; n++) begin
                    send_req(n < 8, 3'd2, 32'h140, 12'(4 * (n % 8)), 32'hA5A5_0000 + 32'(n));
                end
            end
            begin
                repeat (STALL_CYCLES) @(negedge clk);
                hold_credits = 1'b0;
            end
        join

        // Random mix near the top of memory so range faults show up
        for (int n = 0; n < N_RANDOM; n++) begin
            st   = (lfsr_bits(1, stim_lfsr) != 0);
            size = 2'(lfsr_bits(2, stim_lfsr));
            if (size == 2'd3) size = 2'd2;
            f3   = {!st && (lfsr_bits(1, stim_lfsr) != 0), size};
            if (lfsr_bits(4, stim_lfsr) == 0) f3 = 3'(lfsr_bits(3, stim_lfsr));  // Rare bad code
            base = 32'h380 + lfsr_bits(7, stim_lfsr);
            base = (base >> size) << size;
            if (lfsr_bits(4, stim_lfsr) == 0) base[0] = ~base[0];  // Rare misalign
            rnd  = lfsr_bits(4, stim_lfsr);
            send_req(st, f3, base, {{6{rnd[3]}}, rnd[3:0], 2'b00}, lfsr_bits(32, stim_lfsr));
        end

        drain = 0;
        while (exp_q.size() != 0 && drain < 1000) begin
            @(negedge clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d responses never arrived", exp_q.size());
            errors++;
        end
        repeat (10) @(negedge clk);  // Catch any stray extra response
        finish_run();
    end

endmodule

// File: flist.f
logic/lsu_pkg.sv
logic/lsu_credit_if.sv
logic/lsu_decode.sv
logic/lsu_execute.sv
logic/data_mem.sv
logic/lsu_result.sv
logic/lsu_top.sv
dv/lsu_properties.sv
dv/lsu_tb.sv

// File: logic/data_mem.sv
`timescale 1ns/1ps

module data_mem import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(MEM_WORDS)-1:0] addr_i,     // Word index
    input  logic                         wr_en_i,
    input  logic [3:0]                   byte_en_i,  // Bit n enables lane n
    input  logic [XLEN-1:0]              wr_data_i,  // Already lane aligned
    output logic [XLEN-1:0]              rd_data_o   // Registered
);

    // Lane 0 holds the lowest byte address, little-endian
    // Starts all zero, no preload
    logic [3:0][7:0] mem [MEM_WORDS] = '{default: '0};

    always_ff @(posedge clk) begin
        // Per-lane write under the byte mask
        for (int b = 0; b < 4; b++) begin
            if (wr_en_i && byte_en_i[b]) begin
                mem[addr_i][b] <= wr_data_i[8*b +: 8];
            end
        end
        rd_data_o <= mem[addr_i];  // Old word on a same-cycle write
    end

endmodule

// File: logic/lsu_credit_if.sv
`timescale 1ns/1ps

// Credit-based channel between two internal stages
// Sender spends one credit per valid beat, receiver returns one per freed slot
interface lsu_credit_if #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input logic clk
);

    logic     valid;   // Single-cycle beat, always accepted
    PAYLOAD_T payload; // Meaningful only with valid
    logic     credit;  // One pulse per buffer slot freed

    modport tx (
        input  clk,
        output valid,
        output payload,
        input  credit
    );

    modport rx (
        input  clk,
        input  valid,
        input  payload,
        output credit
    );

endinterface

// File: logic/lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; #(
    parameter int IN_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            req_valid_i,
    input  logic            req_store_i,
    input  logic [2:0]      req_funct3_i,
    input  logic [XLEN-1:0] req_base_i,
    input  logic [11:0]     req_offset_i,
    input  logic [XLEN-1:0] req_wdata_i,
    output logic            req_credit_o,  // One pulse per popped entry
    lsu_credit_if.tx        dec_ch
);

    localparam int DEC_CREDITS = 2;  // Execute inbound buffer size
    localparam int DCRD_W      = $clog2(DEC_CREDITS + 1);
    localparam int PTR_W       = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W       = $clog2(IN_DEPTH + 1);

    // Request as it arrives, decoded only when it leaves
    typedef struct packed {
        logic            store;
        logic [2:0]      funct3;
        logic [XLEN-1:0] base;
        logic [11:0]     offset;
        logic [XLEN-1:0] wdata;
    } raw_req_t;

    raw_req_t          queue_q [IN_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  fill_q;
    logic [DCRD_W-1:0] dec_crd_q;   // Credits toward execute
    logic              pop;
    logic              valid_q;
    dec_op_t           payload_q;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // funct3 to size, sign rule and illegal flag
    function automatic dec_op_t decode_req(raw_req_t req);
        dec_op_t op;
        op.store  = req.store;
        op.base   = req.base;
        op.offset = req.offset;
        op.wdata  = req.wdata;
        case (req.funct3[1:0])
            2'b00:   op.size = SZ_BYTE;
            2'b01:   op.size = SZ_HALF;
            default: op.size = SZ_WORD;
        endcase
        if (req.store) begin
            op.is_unsigned = 1'b0;                  // No extension on stores
            op.illegal     = (req.funct3 > 3'd2);   // Only SB, SH, SW
        end else begin
            op.is_unsigned = req.funct3[2];         // LBU, LHU
            op.illegal     = (req.funct3[1:0] == 2'b11) || (req.funct3 == 3'd6);
        end
        return op;
    endfunction

    assign pop = (fill_q != '0) && (dec_crd_q != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            fill_q       <= '0;
            dec_crd_q    <= DCRD_W'(DEC_CREDITS);  // Execute buffer starts empty
            valid_q      <= 1'b0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            fill_q       <= fill_q + CNT_W'(req_valid_i) - CNT_W'(pop);
            dec_crd_q    <= dec_crd_q - DCRD_W'(pop) + DCRD_W'(dec_ch.credit);
            valid_q      <= pop;
            req_credit_o <= pop;  // Slot freed, tell the producer
        end
    end

    // Storage and outgoing payload
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            queue_q[wr_ptr_q] <= '{req_store_i, req_funct3_i, req_base_i,
                                   req_offset_i, req_wdata_i};
        end
        if (pop) payload_q <= decode_req(queue_q[rd_ptr_q]);
    end

    assign dec_ch.valid   = valid_q;
    assign dec_ch.payload = payload_q;

endmodule

// File: logic/lsu_execute.sv
`timescale 1ns/1ps

module lsu_execute import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256,
    parameter int RES_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    lsu_credit_if.rx                     dec_ch,
    lsu_credit_if.tx                     mem_ch,
    output logic [$clog2(MEM_WORDS)-1:0] mem_addr_o,     // Word index
    output logic                         mem_wr_en_o,
    output logic [3:0]                   mem_byte_en_o,
    output logic [XLEN-1:0]              mem_wr_data_o,  // Lane aligned
    input  logic [XLEN-1:0]              mem_rd_data_i
);

    localparam int DEC_CREDITS        = 2;  // Inbound buffer size
    localparam int AW                 = $clog2(MEM_WORDS);
    localparam int RCRD_W             = $clog2(RES_DEPTH + 1);
    localparam logic [XLEN:0] MEM_BYTES = (XLEN + 1)'(MEM_WORDS * 4);

    dec_op_t           buf_q [DEC_CREDITS];
    logic              buf_wr_q;      // Two entries, one-bit pointers
    logic              buf_rd_q;
    logic [1:0]        buf_fill_q;
    logic [RCRD_W-1:0] res_crd_q;     // Free slots in the result queue
    logic              bypass;        // Buffer empty, take the beat directly
    dec_op_t           op;
    logic              issue;
    logic              push;
    logic              pop_buf;
    logic [XLEN-1:0]   eff_addr;
    logic [1:0]        lane;
    logic [1:0]        span;          // Access bytes minus one
    logic [3:0]        size_mask;
    logic              misalign;
    logic [XLEN:0]     last_byte;     // Extra bit catches wrap
    logic              fault;

    // Attributes riding alongside the synchronous read
    logic              stg_valid_q;
    logic              stg_store_q;
    access_size_e      stg_size_q;
    logic              stg_unsigned_q;
    logic [1:0]        stg_lane_q;
    logic              stg_fault_q;

    assign bypass  = (buf_fill_q == 2'd0);
    assign op      = bypass ? dec_ch.payload : buf_q[buf_rd_q];
    assign issue   = (!bypass || dec_ch.valid) && (res_crd_q != '0);
    assign push    = dec_ch.valid && !(bypass && issue);
    assign pop_buf = issue && !bypass;

    assign dec_ch.credit = issue;  // Entry left, slot free again

    assign eff_addr = op.base + {{(XLEN - 12){op.offset[11]}}, op.offset};
    assign lane     = eff_addr[1:0];

    always_comb begin
        case (op.size)
            SZ_BYTE: begin
                size_mask = 4'b0001;
                span      = 2'd0;
                misalign  = 1'b0;
            end
            SZ_HALF: begin
                size_mask = 4'b0011;
                span      = 2'd1;
                misalign  = eff_addr[0];
            end
            default: begin
                size_mask = 4'b1111;
                span      = 2'd3;
                misalign  = |eff_addr[1:0];
            end
        endcase
    end

    assign last_byte = {1'b0, eff_addr} + (XLEN + 1)'(span);
    assign fault     = op.illegal || misalign || (last_byte >= MEM_BYTES);

    assign mem_addr_o    = eff_addr[AW+1:2];
    assign mem_wr_en_o   = issue && op.store && !fault;  // Faulting store writes nothing
    assign mem_byte_en_o = size_mask << lane;
    assign mem_wr_data_o = op.wdata << {lane, 3'b000};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            buf_wr_q    <= 1'b0;
            buf_rd_q    <= 1'b0;
            buf_fill_q  <= 2'd0;
            res_crd_q   <= RCRD_W'(RES_DEPTH);
            stg_valid_q <= 1'b0;
        end else begin
            if (push) buf_wr_q <= !buf_wr_q;
            if (pop_buf) buf_rd_q <= !buf_rd_q;
            buf_fill_q  <= buf_fill_q + 2'(push) - 2'(pop_buf);
            res_crd_q   <= res_crd_q - RCRD_W'(issue) + RCRD_W'(mem_ch.credit);
            stg_valid_q <= issue;  // Read word lands next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (push) buf_q[buf_wr_q] <= dec_ch.payload;
        if (issue) begin
            stg_store_q    <= op.store;
            stg_size_q     <= op.size;
            stg_unsigned_q <= op.is_unsigned;
            stg_lane_q     <= lane;
            stg_fault_q    <= fault;
        end
    end

    assign mem_ch.valid   = stg_valid_q;
    assign mem_ch.payload = '{store: stg_store_q, size: stg_size_q,
                              is_unsigned: stg_unsigned_q, lane: stg_lane_q,
                              fault: stg_fault_q, raw: mem_rd_data_i};

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

    // Core data and address width
    localparam int XLEN = 32;

    // Returned in place of load data on any fault
    localparam logic [XLEN-1:0] ERR_DATA = 32'hDEAD_BEEF;

    // Access width, encoded like funct3[1:0]
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_size_e;

    // Decoded request on its way to the execute block
    typedef struct packed {
        logic            store;       // 1 for store, 0 for load
        access_size_e    size;
        logic            is_unsigned; // Zero-extend on load
        logic            illegal;     // Bad funct3 for this op
        logic [XLEN-1:0] base;
        logic [11:0]     offset;      // Signed immediate
        logic [XLEN-1:0] wdata;
    } dec_op_t;

    // Memory stage result, raw word plus what is needed to format it
    typedef struct packed {
        logic            store;
        access_size_e    size;
        logic            is_unsigned;
        logic [1:0]      lane;        // Low address bits
        logic            fault;
        logic [XLEN-1:0] raw;         // Full word as read
    } mem_rsp_t;

endpackage

// File: logic/lsu_result.sv
`timescale 1ns/1ps

module lsu_result import lsu_pkg::*; #(
    parameter int RES_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            arst_n_i,
    lsu_credit_if.rx        mem_ch,
    output logic            rsp_valid_o,
    output logic [XLEN-1:0] rsp_data_o,
    output logic            rsp_fault_o,
    input  logic            rsp_credit_i   // Consumer freed one slot
);

    localparam int PTR_W  = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RES_DEPTH + 1);
    localparam int OCRD_W = $clog2(OUT_CREDITS + 1);

    mem_rsp_t          queue_q [RES_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  fill_q;
    logic [OCRD_W-1:0] out_crd_q;  // Free consumer slots
    mem_rsp_t          head;
    logic              pop;
    logic [XLEN-1:0]   lane_word;  // Addressed lane moved to bit 0
    logic [XLEN-1:0]   load_data;

    assign head = queue_q[rd_ptr_q];
    assign pop  = (fill_q != '0) && (out_crd_q != '0);

    assign rsp_valid_o   = pop;  // Presented and popped in one cycle
    assign mem_ch.credit = pop;

    assign lane_word = head.raw >> {head.lane, 3'b000};

    always_comb begin
        case (head.size)
            SZ_BYTE: begin
                load_data = head.is_unsigned ? {{(XLEN - 8){1'b0}}, lane_word[7:0]}
                                             : {{(XLEN - 8){lane_word[7]}}, lane_word[7:0]};
            end
            SZ_HALF: begin
                load_data = head.is_unsigned ? {{(XLEN - 16){1'b0}}, lane_word[15:0]}
                                             : {{(XLEN - 16){lane_word[15]}}, lane_word[15:0]};
            end
            default: load_data = lane_word;  // Full word, no extension
        endcase

        rsp_fault_o = head.fault;
        if (head.fault) begin
            rsp_data_o = ERR_DATA;
        end else if (head.store) begin
            rsp_data_o = '0;       // Stores return zero
        end else begin
            rsp_data_o = load_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            out_crd_q <= OCRD_W'(OUT_CREDITS);
        end else begin
            if (mem_ch.valid) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(RES_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(RES_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            fill_q    <= fill_q + CNT_W'(mem_ch.valid) - CNT_W'(pop);
            out_crd_q <= out_crd_q - OCRD_W'(pop) + OCRD_W'(rsp_credit_i);
        end
    end

    // Every beat is taken, execute holds a credit for it
    always_ff @(posedge clk) begin
        if (mem_ch.valid) queue_q[wr_ptr_q] <= mem_ch.payload;
    end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int MEM_WORDS   = 256,
    parameter int IN_DEPTH    = 4,   // Producer's starting credits
    parameter int RES_DEPTH   = 4,
    parameter int OUT_CREDITS = 2    // Consumer buffer size
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            req_valid_i,
    input  logic            req_store_i,
    input  logic [2:0]      req_funct3_i,
    input  logic [XLEN-1:0] req_base_i,
    input  logic [11:0]     req_offset_i,
    input  logic [XLEN-1:0] req_wdata_i,
    output logic            req_credit_o,
    output logic            rsp_valid_o,
    output logic [XLEN-1:0] rsp_data_o,
    output logic            rsp_fault_o,
    input  logic            rsp_credit_i
);

    // Memory link
    logic [$clog2(MEM_WORDS)-1:0] mem_addr;
    logic                         mem_wr_en;
    logic [3:0]                   mem_byte_en;
    logic [XLEN-1:0]              mem_wr_data;
    logic [XLEN-1:0]              mem_rd_data;

    lsu_credit_if #(.PAYLOAD_T(dec_op_t))  dec_ch (.clk(clk));  // Decode to execute
    lsu_credit_if #(.PAYLOAD_T(mem_rsp_t)) mem_ch (.clk(clk));  // Execute to result

    lsu_decode #(
        .IN_DEPTH(IN_DEPTH)
    ) i_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_store_i  (req_store_i),
        .req_funct3_i (req_funct3_i),
        .req_base_i   (req_base_i),
        .req_offset_i (req_offset_i),
        .req_wdata_i  (req_wdata_i),
        .req_credit_o (req_credit_o),
        .dec_ch       (dec_ch.tx)
    );

    lsu_execute #(
        .MEM_WORDS (MEM_WORDS),
        .RES_DEPTH (RES_DEPTH)
    ) i_execute (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .dec_ch        (dec_ch.rx),
        .mem_ch        (mem_ch.tx),
        .mem_addr_o    (mem_addr),
        .mem_wr_en_o   (mem_wr_en),
        .mem_byte_en_o (mem_byte_en),
        .mem_wr_data_o (mem_wr_data),
        .mem_rd_data_i (mem_rd_data)
    );

    data_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) i_mem (
        .clk       (clk),
        .addr_i    (mem_addr),
        .wr_en_i   (mem_wr_en),
        .byte_en_i (mem_byte_en),
        .wr_data_i (mem_wr_data),
        .rd_data_o (mem_rd_data)
    );

    lsu_result #(
        .RES_DEPTH   (RES_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_result (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mem_ch       (mem_ch.rx),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_data_o   (rsp_data_o),
        .rsp_fault_o  (rsp_fault_o),
        .rsp_credit_i (rsp_credit_i)
    );

endmodule
